//--- source/bypass_pkg.sv
package bypass_pkg;

    // coprocessor-0 register addresses.
    localparam logic [4:0] rd_status  = 5'd12;
    localparam logic [4:0] rd_cause   = 5'd13;
    localparam logic [4:0] rd_epc     = 5'd14;
    localparam logic [2:0] sel_status = 3'd0;
    localparam logic [2:0] sel_cause  = 3'd0;
    localparam logic [2:0] sel_epc    = 3'd0;

    localparam logic [31:0] exl_bit = 32'h0000_0002; // status.exl.

    typedef struct packed {
        logic write_reg;
        logic write_hi;
        logic write_lo;
        logic write_llbit;
        logic write_cop0;
        logic exception;
    } ctrl_t;

    typedef struct packed {
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  dest_reg;
        logic [31:0] dest_data;
        logic [31:0] hi_data;
        logic [31:0] lo_data;
        logic        llbit_data;
        logic [4:0]  cop0_wr_rd;   // mtc0 target.
        logic [2:0]  cop0_wr_sel;
        logic [31:0] cop0_wr_data;
        logic [4:0]  cop0_rd_rd;   // mfc0 source.
        logic [2:0]  cop0_rd_sel;
        logic [31:0] exc_pc;
        ctrl_t       ctrl;
    } issue_t;

    typedef struct packed {
        logic [31:0] rs_val;
        logic [31:0] rt_val;
        logic [31:0] hi;
        logic [31:0] lo;
        logic [31:0] cop0_val;
        logic [31:0] status;
        logic [31:0] cause;
        logic [31:0] epc;
        logic        llbit;
    } operands_t;

    // issue plus the values read and resolved at decode.
    typedef struct packed {
        issue_t    iss;
        operands_t ops;
    } decode_rec_t;

    typedef struct packed {
        logic        f;
        logic [31:0] data;
    } fwd_elem_t;

    typedef struct packed {
        fwd_elem_t rs;
        fwd_elem_t rt;
        fwd_elem_t hi;
        fwd_elem_t lo;
        fwd_elem_t llbit; // data bit 0 only.
        fwd_elem_t cop0;
        fwd_elem_t status;
        fwd_elem_t cause;
        fwd_elem_t epc;
    } fwd_info_t;

    typedef struct packed {
        logic        use_or;
        logic [31:0] or_bits;
    } replace_elem_t;

    typedef struct packed {
        replace_elem_t cop0;
        replace_elem_t status;
    } replace_info_t;

endpackage

//--- source/pipe_stage_reg.sv
`timescale 1ns/10ps

module pipe_stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0; // bubble.
        end else begin
            out_valid <= in_valid;
        end
    end

    // payload is only meaningful while out_valid is high
    always_ff @(posedge clk) begin
        out_data <= in_data;
    end

endmodule

//--- source/gpr_file.sv
`timescale 1ns/10ps

module gpr_file (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        wr_en,
    input  logic [4:0]  wr_addr,
    input  logic [31:0] wr_data,
    input  logic [4:0]  rd_addr_a,
    input  logic [4:0]  rd_addr_b,
    output logic [31:0] rd_data_a,
    output logic [31:0] rd_data_b
);

    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != 5'd0) begin
            regs[wr_addr] <= wr_data; // $zero never written.
        end
    end

    assign rd_data_a = (rd_addr_a == 5'd0) ? '0 : regs[rd_addr_a];
    assign rd_data_b = (rd_addr_b == 5'd0) ? '0 : regs[rd_addr_b];

endmodule

//--- source/special_regs.sv
`timescale 1ns/10ps

module special_regs
    import bypass_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        wb_valid,
    input  issue_t      wb,
    input  logic [4:0]  cop0_rd_rd,
    input  logic [2:0]  cop0_rd_sel,
    output logic [31:0] hi,
    output logic [31:0] lo,
    output logic        llbit,
    output logic [31:0] status,
    output logic [31:0] cause,
    output logic [31:0] epc,
    output logic [31:0] cop0_val
);

    logic [31:0] hi_q;
    logic [31:0] lo_q;
    logic        llbit_q;
    logic [31:0] status_q;
    logic [31:0] cause_q;
    logic [31:0] epc_q;
    logic [31:0] hi_d;
    logic [31:0] lo_d;
    logic        llbit_d;
    logic [31:0] status_d;
    logic [31:0] cause_d;
    logic [31:0] epc_d;

    always_comb begin
        hi_d     = hi_q;
        lo_d     = lo_q;
        llbit_d  = llbit_q;
        status_d = status_q;
        cause_d  = cause_q;
        epc_d    = epc_q;
        if (wb_valid) begin
            if (wb.ctrl.write_hi) begin
                hi_d = wb.hi_data;
            end
            if (wb.ctrl.write_lo) begin
                lo_d = wb.lo_data;
            end
            if (wb.ctrl.write_llbit) begin
                llbit_d = wb.llbit_data;
            end
            if (wb.ctrl.write_cop0) begin
                if (wb.cop0_wr_rd == rd_status && wb.cop0_wr_sel == sel_status) begin
                    status_d = wb.cop0_wr_data;
                end
                if (wb.cop0_wr_rd == rd_cause && wb.cop0_wr_sel == sel_cause) begin
                    cause_d = wb.cop0_wr_data;
                end
                if (wb.cop0_wr_rd == rd_epc && wb.cop0_wr_sel == sel_epc) begin
                    epc_d = wb.cop0_wr_data;
                end
            end
            if (wb.ctrl.exception) begin
                status_d = status_d | exl_bit; // exception wins over mtc0.
                epc_d    = wb.exc_pc;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hi_q     <= '0;
            lo_q     <= '0;
            llbit_q  <= 1'b0;
            status_q <= '0;
            cause_q  <= '0;
            epc_q    <= '0;
        end else begin
            hi_q     <= hi_d;
            lo_q     <= lo_d;
            llbit_q  <= llbit_d;
            status_q <= status_d;
            cause_q  <= cause_d;
            epc_q    <= epc_d;
        end
    end

    // reads already see the record in write-back.
    assign hi     = hi_d;
    assign lo     = lo_d;
    assign llbit  = llbit_d;
    assign status = status_d;
    assign cause  = cause_d;
    assign epc    = epc_d;

    always_comb begin
        cop0_val = '0; // unmapped.
        if (cop0_rd_rd == rd_status && cop0_rd_sel == sel_status) begin
            cop0_val = status_d;
        end else if (cop0_rd_rd == rd_cause && cop0_rd_sel == sel_cause) begin
            cop0_val = cause_d;
        end else if (cop0_rd_rd == rd_epc && cop0_rd_sel == sel_epc) begin
            cop0_val = epc_d;
        end
    end

endmodule

//--- source/main_forwarder.sv
`timescale 1ns/10ps

module main_forwarder
    import bypass_pkg::*;
(
    input  logic          dec_valid,
    input  issue_t        dec,
    input  logic          exe_valid,
    input  issue_t        exe,
    input  logic          mem_valid,
    input  issue_t        mem,
    input  logic          wb_valid,
    input  issue_t        wb,
    output fwd_info_t     decode_fwd,
    output fwd_info_t     execute_fwd,
    output replace_info_t decode_replace,
    output replace_info_t execute_replace
);

    function automatic fwd_elem_t gpr_hit(
        input logic       src_valid,
        input issue_t     src,
        input logic [4:0] target
    );
        fwd_elem_t hit;
        hit = '0;
        if (src_valid && src.ctrl.write_reg && src.dest_reg != 5'd0
                && src.dest_reg == target) begin
            hit = '{f: 1'b1, data: src.dest_data};
        end
        return hit;
    endfunction

    function automatic fwd_elem_t cop0_hit(
        input logic       src_valid,
        input issue_t     src,
        input logic [4:0] rd,
        input logic [2:0] sel
    );
        fwd_elem_t hit;
        hit = '0;
        if (src_valid && src.ctrl.write_cop0 && src.cop0_wr_rd == rd
                && src.cop0_wr_sel == sel) begin
            hit = '{f: 1'b1, data: src.cop0_wr_data};
        end
        // exception loads EPC after the mtc0 of the same record
        if (src_valid && src.ctrl.exception && rd == rd_epc && sel == sel_epc) begin
            hit = '{f: 1'b1, data: src.exc_pc};
        end
        return hit;
    endfunction

    // hi, lo, llbit and cop0 state come from the memory stage only
    function automatic fwd_info_t special_fwd(
        input logic   src_valid,
        input issue_t src,
        input issue_t stage
    );
        fwd_info_t info;
        info = '0;
        if (src_valid && src.ctrl.write_hi) begin
            info.hi = '{f: 1'b1, data: src.hi_data};
        end
        if (src_valid && src.ctrl.write_lo) begin
            info.lo = '{f: 1'b1, data: src.lo_data};
        end
        if (src_valid && src.ctrl.write_llbit) begin
            info.llbit = '{f: 1'b1, data: {31'b0, src.llbit_data}};
        end
        info.cop0   = cop0_hit(src_valid, src, stage.cop0_rd_rd, stage.cop0_rd_sel);
        info.status = cop0_hit(src_valid, src, rd_status, sel_status);
        info.cause  = cop0_hit(src_valid, src, rd_cause, sel_cause);
        info.epc    = cop0_hit(src_valid, src, rd_epc, sel_epc);
        return info;
    endfunction

    function automatic replace_info_t exl_replace(
        input logic   src_valid,
        input issue_t src,
        input issue_t stage
    );
        replace_info_t info;
        info = '0;
        if (src_valid && src.ctrl.exception) begin
            info.status = '{use_or: 1'b1, or_bits: exl_bit};
        end
        if (stage.cop0_rd_rd == rd_status && stage.cop0_rd_sel == sel_status) begin
            info.cop0 = info.status; // mfc0 of status sees exl too.
        end
        return info;
    endfunction

    always_comb begin
        decode_fwd    = special_fwd(dec_valid && mem_valid, mem, dec);
        decode_fwd.rs = gpr_hit(dec_valid && wb_valid, wb, dec.rs); // wb only.
        decode_fwd.rt = gpr_hit(dec_valid && wb_valid, wb, dec.rt);

        execute_fwd    = special_fwd(exe_valid && mem_valid, mem, exe);
        execute_fwd.rs = gpr_hit(exe_valid && mem_valid, mem, exe.rs);
        execute_fwd.rt = gpr_hit(exe_valid && mem_valid, mem, exe.rt);
        if (!execute_fwd.rs.f) begin
            execute_fwd.rs = gpr_hit(exe_valid && wb_valid, wb, exe.rs);
        end
        if (!execute_fwd.rt.f) begin
            execute_fwd.rt = gpr_hit(exe_valid && wb_valid, wb, exe.rt);
        end

        decode_replace  = exl_replace(dec_valid && mem_valid, mem, dec);
        execute_replace = exl_replace(exe_valid && mem_valid, mem, exe);
    end

endmodule

//--- source/operand_resolver.sv
`timescale 1ns/10ps

module operand_resolver
    import bypass_pkg::*;
(
    input  operands_t     base,
    input  fwd_info_t     fwd,
    input  replace_info_t replace,
    output operands_t     resolved
);

    function automatic logic [31:0] pick(
        input fwd_elem_t   elem,
        input logic [31:0] value
    );
        return elem.f ? elem.data : value;
    endfunction

    always_comb begin
        resolved          = base;
        resolved.rs_val   = pick(fwd.rs, base.rs_val);
        resolved.rt_val   = pick(fwd.rt, base.rt_val);
        resolved.hi       = pick(fwd.hi, base.hi);
        resolved.lo       = pick(fwd.lo, base.lo);
        resolved.cop0_val = pick(fwd.cop0, base.cop0_val);
        resolved.status   = pick(fwd.status, base.status);
        resolved.cause    = pick(fwd.cause, base.cause);
        resolved.epc      = pick(fwd.epc, base.epc);
        if (fwd.llbit.f) begin
            resolved.llbit = fwd.llbit.data[0];
        end

        // exl goes on top of whatever was forwarded.
        if (replace.status.use_or) begin
            resolved.status = resolved.status | replace.status.or_bits;
        end
        if (replace.cop0.use_or) begin
            resolved.cop0_val = resolved.cop0_val | replace.cop0.or_bits;
        end
    end

endmodule

//--- source/bypass_top.sv
`timescale 1ns/10ps

module bypass_top
    import bypass_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      issue_valid,
    input  issue_t    issue,
    output logic      result_valid,
    output operands_t result
);

    logic          dec_valid;
    issue_t        dec_iss;
    logic          exe_valid;
    decode_rec_t   exe_in;
    decode_rec_t   exe_rec;
    logic          mem_valid;
    issue_t        mem_iss;
    logic          wb_valid;
    issue_t        wb_iss;
    logic [31:0]   gpr_rs;
    logic [31:0]   gpr_rt;
    logic [31:0]   sr_hi;
    logic [31:0]   sr_lo;
    logic          sr_llbit;
    logic [31:0]   sr_status;
    logic [31:0]   sr_cause;
    logic [31:0]   sr_epc;
    logic [31:0]   sr_cop0_val;
    operands_t     dec_base;
    operands_t     dec_resolved;
    operands_t     exe_resolved;
    fwd_info_t     decode_fwd;
    fwd_info_t     execute_fwd;
    replace_info_t decode_replace;
    replace_info_t execute_replace;

    pipe_stage_reg #(.payload_t(issue_t)) dec_reg (
        .clk(clk), .rst_n(rst_n), .in_valid(issue_valid), .in_data(issue),
        .out_valid(dec_valid), .out_data(dec_iss)
    );

    assign exe_in = '{iss: dec_iss, ops: dec_resolved};

    pipe_stage_reg #(.payload_t(decode_rec_t)) exe_reg (
        .clk(clk), .rst_n(rst_n), .in_valid(dec_valid), .in_data(exe_in),
        .out_valid(exe_valid), .out_data(exe_rec)
    );

    pipe_stage_reg #(.payload_t(issue_t)) mem_reg (
        .clk(clk), .rst_n(rst_n), .in_valid(exe_valid), .in_data(exe_rec.iss),
        .out_valid(mem_valid), .out_data(mem_iss)
    );

    pipe_stage_reg #(.payload_t(issue_t)) wb_reg (
        .clk(clk), .rst_n(rst_n), .in_valid(mem_valid), .in_data(mem_iss),
        .out_valid(wb_valid), .out_data(wb_iss)
    );

    gpr_file gpr_file_inst (
        .clk(clk), .rst_n(rst_n),
        .wr_en(wb_valid && wb_iss.ctrl.write_reg), .wr_addr(wb_iss.dest_reg),
        .wr_data(wb_iss.dest_data), .rd_addr_a(dec_iss.rs), .rd_addr_b(dec_iss.rt),
        .rd_data_a(gpr_rs), .rd_data_b(gpr_rt)
    );

    special_regs special_regs_inst (
        .clk(clk), .rst_n(rst_n), .wb_valid(wb_valid), .wb(wb_iss),
        .cop0_rd_rd(dec_iss.cop0_rd_rd), .cop0_rd_sel(dec_iss.cop0_rd_sel),
        .hi(sr_hi), .lo(sr_lo), .llbit(sr_llbit), .status(sr_status),
        .cause(sr_cause), .epc(sr_epc), .cop0_val(sr_cop0_val)
    );

    assign dec_base = '{rs_val: gpr_rs, rt_val: gpr_rt, hi: sr_hi, lo: sr_lo,
                        cop0_val: sr_cop0_val, status: sr_status, cause: sr_cause,
                        epc: sr_epc, llbit: sr_llbit};

    main_forwarder main_forwarder_inst (
        .dec_valid(dec_valid), .dec(dec_iss), .exe_valid(exe_valid), .exe(exe_rec.iss),
        .mem_valid(mem_valid), .mem(mem_iss), .wb_valid(wb_valid), .wb(wb_iss),
        .decode_fwd(decode_fwd), .execute_fwd(execute_fwd),
        .decode_replace(decode_replace), .execute_replace(execute_replace)
    );

    operand_resolver decode_resolver (
        .base(dec_base), .fwd(decode_fwd), .replace(decode_replace),
        .resolved(dec_resolved)
    );

    operand_resolver execute_resolver (
        .base(exe_rec.ops), .fwd(execute_fwd), .replace(execute_replace),
        .resolved(exe_resolved)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= exe_valid;
        end
    end

    always_ff @(posedge clk) begin
        result <= exe_resolved;
    end

endmodule

//--- dv/bypass_tb_tasks.svh
function automatic string field_diff(input string name, input logic [31:0] got,
                                     input logic [31:0] exp);
    if (got === exp) begin
        return "";
    end
    return $sformatf(" %s %h/%h", name, got, exp);
endfunction

task automatic compare_operands(input operands_t got, input operands_t exp, input string what);
    string diff;
    checks++;
    diff = {field_diff("rs_val", got.rs_val, exp.rs_val),
            field_diff("rt_val", got.rt_val, exp.rt_val),
            field_diff("hi", got.hi, exp.hi),
            field_diff("lo", got.lo, exp.lo),
            field_diff("llbit", 32'(got.llbit), 32'(exp.llbit)),
            field_diff("cop0_val", got.cop0_val, exp.cop0_val),
            field_diff("status", got.status, exp.status),
            field_diff("cause", got.cause, exp.cause),
            field_diff("epc", got.epc, exp.epc)};
    if (diff != "") begin
        errors++;
        $display("error at %0t: %s operands differ (got/expected)%s", $time, what, diff);
    end
endtask

task automatic compare_valid(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("error at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
endtask

task automatic issue_record(input issue_t rec);
    issue_valid = 1'b1;
    issue       = rec;
    exp_q.push_back('{ops: model_operands(rec), due: cycle + 3}); // fixed 3-edge latency.
    model_commit(rec);
    @(posedge clk);
    #1;
    issue_valid = 1'b0;
endtask

task automatic idle_cycles(input int n);
    repeat (n) begin
        @(posedge clk);
        #1;
    end
endtask

task automatic wait_results();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < 20) begin
        @(posedge clk);
        #1;
        waited++;
    end
    if (exp_q.size() != 0) begin
        abort_run("timed out after 20 cycles waiting for result_valid");
    end
endtask

task automatic report_test(input string name, input int errs_before);
    if (errors == errs_before) begin
        $display("test %s: ok", name);
    end else begin
        $display("test %s: %0d errors", name, errors - errs_before);
    end
endtask

function automatic issue_t producer(input logic [4:0] dest, input logic [31:0] data);
    issue_t rec;
    rec               = '0;
    rec.dest_reg      = dest;
    rec.dest_data     = data;
    rec.ctrl.write_reg = 1'b1;
    return rec;
endfunction

function automatic issue_t reader(input logic [4:0] rs, input logic [4:0] rt,
                                  input logic [4:0] c0_rd, input logic [2:0] c0_sel);
    issue_t rec;
    rec             = '0;
    rec.rs          = rs;
    rec.rt          = rt;
    rec.cop0_rd_rd  = c0_rd;
    rec.cop0_rd_sel = c0_sel;
    return rec;
endfunction

// writes only hit mapped cop0 registers, reads may miss.
function automatic issue_t random_record();
    issue_t rec;
    rec                  = '0;
    rec.rs               = 5'($urandom_range(0, 7));
    rec.rt               = 5'($urandom_range(0, 7));
    rec.dest_reg         = 5'($urandom_range(0, 7));
    rec.dest_data        = $urandom();
    rec.hi_data          = $urandom();
    rec.lo_data          = $urandom();
    rec.llbit_data       = 1'($urandom());
    rec.cop0_wr_rd       = 5'($urandom_range(12, 14));
    rec.cop0_wr_data     = $urandom();
    rec.cop0_rd_rd       = 5'($urandom_range(11, 14));
    rec.cop0_rd_sel      = ($urandom_range(0, 3) == 0) ? 3'd1 : 3'd0;
    rec.exc_pc           = $urandom();
    rec.ctrl             = ctrl_t'(6'($urandom()));
    rec.ctrl.exception   = ($urandom_range(0, 7) == 0);
    return rec;
endfunction

task automatic test_gpr_distance();
    int errs;
    errs = errors;
    for (int gap = 0; gap < 3; gap++) begin
        issue_record(producer(5'(3 + gap), $urandom()));
        idle_cycles(gap); // distance 1, 2 and 3.
        issue_record(reader(5'(3 + gap), 5'(3 + gap), 5'd0, 3'd0));
    end
    wait_results();
    report_test("gpr_distance", errs);
endtask

task automatic test_zero_and_priority();
    int errs;
    errs = errors;
    issue_record(producer(5'd0, 32'hdead_beef));
    issue_record(reader(5'd0, 5'd0, 5'd0, 3'd0));
    issue_record(producer(5'd9, 32'h1111_1111));
    issue_record(producer(5'd9, 32'h2222_2222)); // younger value wins.
    issue_record(reader(5'd9, 5'd9, 5'd0, 3'd0));
    wait_results();
    report_test("zero_and_priority", errs);
endtask

task automatic test_hi_lo_llbit();
    int errs;
    issue_t rec;
    errs                 = errors;
    rec                  = '0;
    rec.hi_data          = $urandom();
    rec.lo_data          = $urandom();
    rec.llbit_data       = 1'b1;
    rec.ctrl.write_hi    = 1'b1;
    rec.ctrl.write_lo    = 1'b1;
    rec.ctrl.write_llbit = 1'b1;
    issue_record(rec);
    issue_record(reader(5'd0, 5'd0, 5'd0, 3'd0));
    rec.ctrl.write_lo = 1'b0;
    rec.hi_data       = $urandom();
    rec.llbit_data    = 1'b0;
    issue_record(rec);
    idle_cycles(1);
    issue_record(reader(5'd0, 5'd0, 5'd0, 3'd0));
    wait_results();
    report_test("hi_lo_llbit", errs);
endtask

task automatic test_cop0_access();
    int errs;
    issue_t rec;
    errs = errors;
    for (int i = 0; i < 3; i++) begin
        rec                 = '0;
        rec.ctrl.write_cop0 = 1'b1;
        rec.cop0_wr_rd      = 5'(12 + i);
        rec.cop0_wr_data    = $urandom();
        issue_record(rec);
        issue_record(reader(5'd0, 5'd0, 5'(12 + i), 3'd0));
    end
    issue_record(reader(5'd0, 5'd0, 5'd5, 3'd0));
    issue_record(reader(5'd0, 5'd0, rd_status, 3'd2));
    wait_results();
    report_test("cop0_access", errs);
endtask

task automatic test_exception_exl();
    int errs;
    issue_t rec;
    errs                = errors;
    rec                 = '0;
    rec.ctrl.write_cop0 = 1'b1;
    rec.cop0_wr_rd      = rd_status;
    issue_record(rec); // status cleared first.
    rec                 = '0;
    rec.ctrl.exception  = 1'b1;
    rec.exc_pc          = 32'h0040_1234;
    issue_record(rec);
    issue_record(reader(5'd0, 5'd0, rd_status, sel_status));
    issue_record(reader(5'd0, 5'd0, rd_epc, sel_epc));
    rec.ctrl.write_cop0 = 1'b1;
    rec.cop0_wr_rd      = rd_status;
    rec.exc_pc          = 32'h0040_2000;
    issue_record(rec);
    issue_record(reader(5'd0, 5'd0, rd_status, sel_status));
    wait_results();
    report_test("exception_exl", errs);
endtask

task automatic test_random_stream();
    int errs;
    errs = errors;
    for (int n = 0; n < 200; n++) begin
        issue_record(random_record());
        idle_cycles($urandom_range(0, 2));
    end
    wait_results();
    report_test("random_stream", errs);
endtask

//--- dv/bypass_tb.sv
`timescale 1ns/10ps

module bypass_tb
    import bypass_pkg::*;
();

    typedef struct packed {
        operands_t   ops;
        int unsigned due;
    } expect_t;

    logic        clk;
    logic        rst_n;
    logic        issue_valid;
    issue_t      issue;
    logic        result_valid;
    operands_t   result;

    expect_t     exp_q[$];
    int unsigned cycle;
    int          checks;
    int          errors;

    // reference state updated in issue order.
    logic [31:0] model_gpr [32];
    logic [31:0] model_hi;
    logic [31:0] model_lo;
    logic        model_llbit;
    logic [31:0] model_status;
    logic [31:0] model_cause;
    logic [31:0] model_epc;

    bypass_top bypass_top_inst (
        .clk(clk), .rst_n(rst_n), .issue_valid(issue_valid), .issue(issue),
        .result_valid(result_valid), .result(result)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    function automatic logic [31:0] model_cop0(input logic [4:0] rd, input logic [2:0] sel);
        if (rd == rd_status && sel == sel_status) begin
            return model_status;
        end else if (rd == rd_cause && sel == sel_cause) begin
            return model_cause;
        end else if (rd == rd_epc && sel == sel_epc) begin
            return model_epc;
        end
        return '0; // unmapped.
    endfunction

    function automatic operands_t model_operands(input issue_t rec);
        operands_t ops;
        ops.rs_val   = model_gpr[rec.rs];
        ops.rt_val   = model_gpr[rec.rt];
        ops.hi       = model_hi;
        ops.lo       = model_lo;
        ops.llbit    = model_llbit;
        ops.cop0_val = model_cop0(rec.cop0_rd_rd, rec.cop0_rd_sel);
        ops.status   = model_status;
        ops.cause    = model_cause;
        ops.epc      = model_epc;
        return ops;
    endfunction

    task automatic model_commit(input issue_t rec);
        if (rec.ctrl.write_reg && rec.dest_reg != 5'd0) begin
            model_gpr[rec.dest_reg] = rec.dest_data;
        end
        if (rec.ctrl.write_hi) begin
            model_hi = rec.hi_data;
        end
        if (rec.ctrl.write_lo) begin
            model_lo = rec.lo_data;
        end
        if (rec.ctrl.write_llbit) begin
            model_llbit = rec.llbit_data;
        end
        if (rec.ctrl.write_cop0 && rec.cop0_wr_sel == 3'd0) begin
            case (rec.cop0_wr_rd)
                rd_status: model_status = rec.cop0_wr_data;
                rd_cause:  model_cause  = rec.cop0_wr_data;
                rd_epc:    model_epc    = rec.cop0_wr_data;
                default:   ;
            endcase
        end
        if (rec.ctrl.exception) begin
            model_status = model_status | exl_bit; // after the mtc0.
            model_epc    = rec.exc_pc;
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Checks failed");
        $finish;
    endtask

    `include "bypass_tb_tasks.svh"

    // results are sampled away from the driving edge.
    always @(negedge clk) begin
        logic due_now;
        if (rst_n) begin
            due_now = exp_q.size() != 0 && exp_q[0].due == cycle;
            compare_valid(result_valid, due_now, "result_valid");
            if (result_valid && exp_q.size() != 0) begin
                compare_operands(result, exp_q[0].ops, "result");
                void'(exp_q.pop_front());
            end
        end
    end

    initial begin
        void'($urandom(75227));
        issue_valid = 1'b0;
        issue       = '0;
        rst_n       = 1'b0;
        cycle       = 0;
        checks      = 0;
        errors      = 0;
        for (int i = 0; i < 32; i++) begin
            model_gpr[i] = '0;
        end
        model_hi     = '0;
        model_lo     = '0;
        model_llbit  = 1'b0;
        model_status = '0;
        model_cause  = '0;
        model_epc    = '0;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        test_gpr_distance();
        test_zero_and_priority();
        test_hi_lo_llbit();
        test_cop0_access();
        test_exception_exl();
        test_random_stream();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- sim.f
+incdir+dv
source/bypass_pkg.sv
source/pipe_stage_reg.sv
source/gpr_file.sv
source/special_regs.sv
source/main_forwarder.sv
source/operand_resolver.sv
source/bypass_top.sv
dv/bypass_tb.sv
